//--- include/fifo_settings.svh
/* FIFO equivalence settings */

`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

// width of one queued word
`define FIFO_DATA_WIDTH 4

// entries per queue, power of two only
`define FIFO_DEPTH 16

`define FIFO_PTR_WIDTH 4 // log2 of FIFO_DEPTH

`endif

//--- hdl/fifoTypesPkg.sv
/* FIFO data and pointer types */

`default_nettype none

`include "fifo_settings.svh"

package fifoTypesPkg;

    // one queued word, shared by both queues and the top
    typedef logic [`FIFO_DATA_WIDTH-1:0] dataWord;

    // head and tail positions
    // depth is a power of two, so pointers wrap by overflow
    typedef logic [`FIFO_PTR_WIDTH-1:0] fifoPtr;

endpackage

`default_nettype wire

//--- hdl/checkTypesPkg.sv
/* comparator types */

`default_nettype none

`include "fifo_settings.svh"

package checkTypesPkg;

    // checker FSM, failed is terminal until rst
    typedef enum logic {
        checkClean,
        checkFailed
    } checkState;

    // kind of the first disagreement, listed in priority order
    typedef enum logic [1:0] {
        noMismatch,    // nothing seen yet
        fullMismatch,  // full flags differ
        emptyMismatch, // empty flags differ
        dataMismatch   // head words differ on a non-empty queue
    } mismatchKind;

endpackage

`default_nettype wire

//--- hdl/shiftFifo.sv
/* shift-register FIFO */

`default_nettype none

`include "fifo_settings.svh"

module shiftFifo
    import fifoTypesPkg::*;
(
    input  wire logic    clock,
    input  wire logic    rst,
    input  wire dataWord dataIn,
    input  wire logic    push,
    input  wire logic    pop,
    output dataWord      dataOut,
    output logic         full,
    output logic         empty
);

    localparam fifoPtr LAST = fifoPtr'(`FIFO_DEPTH - 1); // top slot of the shift chain

    // new words always enter at slot 0, oldest entry sits at tail
    dataWord mem [`FIFO_DEPTH];
    fifoPtr  tail;

    logic pushOk; // push that is actually performed
    logic popOk;  // pop that is actually performed

    // push wins over pop in the same cycle
    assign pushOk = push && !full;
    assign popOk  = pop && !push && !empty;

    // shift chain storage
    always_ff @(posedge clock) begin
        if (pushOk) begin
            for (int i = `FIFO_DEPTH - 1; i > 0; i--) begin
                mem[i] <= mem[i-1]; // move everything up one place
            end
            mem[0] <= dataIn;
        end
    end

    // tail pointer and empty flag
    always_ff @(posedge clock) begin
        if (rst) begin
            tail  <= '0;
            empty <= 1'b1;
        end else if (pushOk) begin
            if (!empty) begin
                tail <= tail + 1'b1; // oldest entry was pushed up too
            end
            empty <= 1'b0;
        end else if (popOk) begin
            if (tail == '0) begin
                empty <= 1'b1; // last entry leaves, tail stays at 0
            end else begin
                tail <= tail - 1'b1;
            end
        end
    end

    assign dataOut = mem[tail];     // first word fall-through
    assign full    = (tail == LAST);

    // flags exclusive, even with a glitchy command stream
    fullEmptyExclusive: assert property (
        @(posedge clock) disable iff (rst)
        !(full && empty)
    );

    // an empty queue always parks the tail at slot 0
    tailParkedWhenEmpty: assert property (
        @(posedge clock) disable iff (rst)
        empty |-> (tail == '0)
    );

endmodule

`default_nettype wire

//--- hdl/ringFifo.sv
/* ring-buffer FIFO */

`default_nettype none

`include "fifo_settings.svh"

module ringFifo
    import fifoTypesPkg::*;
(
    input  wire logic    clock,
    input  wire logic    rst,
    input  wire dataWord dataIn,
    input  wire logic    push,
    input  wire logic    pop,
    output dataWord      dataOut,
    output logic         full,
    output logic         empty
);

    // wraparound below relies on a power-of-two depth
    if ((1 << `FIFO_PTR_WIDTH) != `FIFO_DEPTH) begin : gDepthCheck
        $error("ringFifo needs FIFO_DEPTH equal to 2**FIFO_PTR_WIDTH");
    end

    dataWord mem [`FIFO_DEPTH];
    fifoPtr  head;     // next write slot unless full
    fifoPtr  tail;     // oldest entry unless empty
    fifoPtr  tailNext; // tail after a pop

    logic pushOk;
    logic popOk;

    // same acceptance rules as the shift queue
    assign pushOk = push && !full;
    assign popOk  = pop && !push && !empty;

    assign tailNext = tail + 1'b1; // wraps at the depth

    // payload storage, written at head
    always_ff @(posedge clock) begin
        if (pushOk) begin
            mem[head] <= dataIn;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            empty <= 1'b1;
        end else if (pushOk) begin
            head  <= head + 1'b1;
            empty <= 1'b0;
        end else if (popOk) begin
            tail <= tailNext;
            // compare after the advance, so a pop from full does not look empty
            if (tailNext == head) begin
                empty <= 1'b1;
            end
        end
    end

    assign dataOut = mem[tail];
    // pointers meet both when empty and when full, the flag decides
    assign full = (head == tail) && !empty;

    // an empty ring has head and tail together
    emptyPointersMeet: assert property (
        @(posedge clock) disable iff (rst)
        empty |-> (head == tail)
    );

endmodule

`default_nettype wire

//--- hdl/fifoComparator.sv
/* FIFO output comparator */

`default_nettype none

module fifoComparator
    import fifoTypesPkg::*;
    import checkTypesPkg::*;
(
    input  wire logic    clock,
    input  wire logic    rst,
    input  wire dataWord shiftData,
    input  wire logic    shiftFull,
    input  wire logic    shiftEmpty,
    input  wire dataWord ringData,
    input  wire logic    ringFull,
    input  wire logic    ringEmpty,
    output logic         equal,
    output logic         mismatchSeen,
    output mismatchKind  firstMismatch
);

    checkState   state;
    checkState   stateNext;
    mismatchKind kindNow; // kind of mismatch in this cycle

    logic fullSame;
    logic emptySame;
    logic dataSame;

    assign fullSame  = (shiftFull == ringFull);
    assign emptySame = (shiftEmpty == ringEmpty);
    // data only matters once something is queued
    assign dataSame  = shiftEmpty || (shiftData == ringData);

    assign equal = fullSame && emptySame && dataSame; // same cycle, no register

    // classify, first disagreeing field wins
    always_comb begin
        if (!fullSame) begin
            kindNow = fullMismatch;
        end else if (!emptySame) begin
            kindNow = emptyMismatch;
        end else if (!dataSame) begin
            kindNow = dataMismatch;
        end else begin
            kindNow = noMismatch;
        end
    end

    // clean until the first unequal cycle, then stuck
    always_comb begin
        stateNext = state;
        case (state)
            checkClean: begin
                if (!equal) begin
                    stateNext = checkFailed;
                end
            end
            checkFailed: stateNext = checkFailed; // only rst leaves
            default:     stateNext = checkClean;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state         <= checkClean;
            firstMismatch <= noMismatch;
        end else begin
            state <= stateNext;
            // capture the kind only on the clean to failed move
            if (state == checkClean && stateNext == checkFailed) begin
                firstMismatch <= kindNow;
            end
        end
    end

    assign mismatchSeen = (state == checkFailed);

    // the failure record is sticky across the whole run
    failedIsSticky: assert property (
        @(posedge clock) disable iff (rst)
        (state == checkFailed) |=> (state == checkFailed) && $stable(firstMismatch)
    );

    // a recorded failure always carries a real kind
    failedHasKind: assert property (
        @(posedge clock) disable iff (rst)
        mismatchSeen |-> (firstMismatch != noMismatch)
    );

endmodule

`default_nettype wire

//--- hdl/fifoEquivTop.sv
/* FIFO equivalence top */

`default_nettype none

module fifoEquivTop
    import fifoTypesPkg::*;
    import checkTypesPkg::*;
(
    input  wire logic    clock,
    input  wire logic    rst,
    input  wire dataWord dataIn,
    input  wire logic    push,
    input  wire logic    pop,
    output dataWord      dataOut,      // from the ring queue
    output logic         full,
    output logic         empty,
    output logic         equal,
    output logic         mismatchSeen,
    output mismatchKind  firstMismatch
);

    // shift queue outputs, only seen by the comparator
    dataWord shiftData;
    logic    shiftFull;
    logic    shiftEmpty;

    shiftFifo shift_i (
        .clock   (clock),
        .rst     (rst),
        .dataIn  (dataIn),
        .push    (push),
        .pop     (pop),
        .dataOut (shiftData),
        .full    (shiftFull),
        .empty   (shiftEmpty)
    );

    // ring queue is the reference, its outputs go straight to the top ports
    ringFifo ring_i (
        .clock   (clock),
        .rst     (rst),
        .dataIn  (dataIn),
        .push    (push),
        .pop     (pop),
        .dataOut (dataOut),
        .full    (full),
        .empty   (empty)
    );

    fifoComparator cmp_i (
        .clock         (clock),
        .rst           (rst),
        .shiftData     (shiftData),
        .shiftFull     (shiftFull),
        .shiftEmpty    (shiftEmpty),
        .ringData      (dataOut),
        .ringFull      (full),
        .ringEmpty     (empty),
        .equal         (equal),
        .mismatchSeen  (mismatchSeen),
        .firstMismatch (firstMismatch)
    );

endmodule

`default_nettype wire

//--- verif/fifoEquivTb.sv
/* FIFO equivalence testbench */

`default_nettype none

`include "fifo_settings.svh"

module fifoEquivTb
    import fifoTypesPkg::*;
    import checkTypesPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CYCLE_LIMIT   = 2600; // ~2200 cycles of tests plus margin
    localparam int RANDOM_CYCLES = 2000;
    localparam int PHASE_CYCLES  = 250;  // length of one push-heavy or pop-heavy stretch

    logic        clock = 1'b0;
    logic        rst;
    dataWord     dataIn;
    logic        push;
    logic        pop;
    dataWord     dataOut;
    logic        full;
    logic        empty;
    logic        equal;
    logic        mismatchSeen;
    mismatchKind firstMismatch;

    dataWord     model[$];                // reference queue, oldest word at index 0
    dataWord     fillWords[`FIFO_DEPTH];  // distinct words for the directed fills
    logic [31:0] rngState   = 32'ha2ff_90a3;
    int          cycleCount = 0;

    fifoEquivTop dut_i (
        .clock         (clock),
        .rst           (rst),
        .dataIn        (dataIn),
        .push          (push),
        .pop           (pop),
        .dataOut       (dataOut),
        .full          (full),
        .empty         (empty),
        .equal         (equal),
        .mismatchSeen  (mismatchSeen),
        .firstMismatch (firstMismatch)
    );

    always #50 clock = ~clock; // 100 ns period

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // queue rules: push beats pop, full drops pushes, empty drops pops
    function automatic void refStep(input logic doPush, input logic doPop,
                                    input dataWord word);
        if (doPush) begin
            if (model.size() < `FIFO_DEPTH) begin
                model.push_back(word);
            end
        end else if (doPop) begin
            if (model.size() > 0) begin
                void'(model.pop_front());
            end
        end
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // apply one command, return 5 ns after the edge that took it
    task automatic driveCycle(input logic doPush, input logic doPop, input dataWord word);
        push   = doPush;
        pop    = doPop;
        dataIn = word;
        @(posedge clock);
        #5;
    endtask

    // head word must be the expected one, then pop it
    task automatic popExpect(input dataWord word, input logic lastOne);
        checkValue("dataOut", 32'(word), 32'(dataOut));
        driveCycle(1'b0, 1'b1, '0);
        checkValue("empty", 32'(lastOne), 32'(empty));
        checkValue("full", 32'(1'b0), 32'(full));
    endtask

    // model follows every edge, DUT compared just before the next one
    initial begin : compareLoop
        forever begin
            @(posedge clock);
            if (rst) begin
                model.delete();
            end else begin
                refStep(push, pop, dataIn);
                #90;
                checkValue("empty", 32'(model.size() == 0), 32'(empty));
                checkValue("full", 32'(model.size() == `FIFO_DEPTH), 32'(full));
                if (model.size() > 0) begin
                    checkValue("dataOut", 32'(model[0]), 32'(dataOut)); // undefined when empty
                end
                checkValue("equal", 32'(1'b1), 32'(equal));
                checkValue("mismatchSeen", 32'(1'b0), 32'(mismatchSeen));
                checkValue("firstMismatch", 32'(noMismatch), 32'(firstMismatch));
            end
        end
    end

    // hard stop for a stuck run
    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("ERROR: run timed out after %0d cycles without finishing", cycleCount);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin : stimulus
        logic pushHeavy;
        logic doPush;
        logic doPop;

        rst    = 1'b1;
        push   = 1'b0;
        pop    = 1'b0;
        dataIn = '0;
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            fillWords[i] = dataWord'(i ^ 5); // all distinct
        end

        repeat (10) @(posedge clock);
        #5;
        rst = 1'b0;

        // reset state
        checkValue("empty", 32'(1'b1), 32'(empty));
        checkValue("full", 32'(1'b0), 32'(full));
        checkValue("equal", 32'(1'b1), 32'(equal));
        checkValue("mismatchSeen", 32'(1'b0), 32'(mismatchSeen));
        checkValue("firstMismatch", 32'(noMismatch), 32'(firstMismatch));

        // fill, head word stays the first one pushed
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            driveCycle(1'b1, 1'b0, fillWords[i]);
            checkValue("dataOut", 32'(fillWords[0]), 32'(dataOut));
            checkValue("full", 32'(i == `FIFO_DEPTH - 1), 32'(full));
            checkValue("empty", 32'(1'b0), 32'(empty));
        end
        driveCycle(1'b1, 1'b0, 4'hA); // 17th push is dropped
        checkValue("full", 32'(1'b1), 32'(full));
        checkValue("dataOut", 32'(fillWords[0]), 32'(dataOut));

        // drain in push order
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            popExpect(fillWords[i], i == `FIFO_DEPTH - 1);
        end
        driveCycle(1'b0, 1'b1, '0); // pop on empty
        checkValue("empty", 32'(1'b1), 32'(empty));
        checkValue("full", 32'(1'b0), 32'(full));

        // push and pop together on a partly filled queue
        driveCycle(1'b1, 1'b0, 4'h1);
        driveCycle(1'b1, 1'b0, 4'h2);
        driveCycle(1'b1, 1'b0, 4'h3);
        driveCycle(1'b1, 1'b1, 4'h4); // acts as a push only
        checkValue("dataOut", 32'(4'h1), 32'(dataOut));
        checkValue("empty", 32'(1'b0), 32'(empty));
        popExpect(4'h1, 1'b0);
        popExpect(4'h2, 1'b0);
        popExpect(4'h3, 1'b0);
        popExpect(4'h4, 1'b1); // grew by exactly one

        // same strobes on a full queue
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            driveCycle(1'b1, 1'b0, fillWords[i]);
        end
        driveCycle(1'b1, 1'b1, 4'hF);
        checkValue("full", 32'(1'b1), 32'(full));
        checkValue("dataOut", 32'(fillWords[0]), 32'(dataOut));
        for (int i = 0; i < `FIFO_DEPTH; i++) begin
            popExpect(fillWords[i], i == `FIFO_DEPTH - 1);
        end

        // random traffic, alternating push-heavy and pop-heavy stretches
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rngState  = xorshift(rngState);
            pushHeavy = ((n / PHASE_CYCLES) % 2) == 0;
            if (pushHeavy) begin
                doPush = rngState[1:0] != 2'b00; // 3 of 4
                doPop  = rngState[2];
            end else begin
                doPush = rngState[1:0] == 2'b00; // 1 of 4
                doPop  = rngState[3:2] != 2'b00;
            end
            driveCycle(doPush, doPop, dataWord'(rngState[11:8]));
        end
        driveCycle(1'b0, 1'b0, '0);
        @(posedge clock); // let the last compare finish
        #95;

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
hdl/fifoTypesPkg.sv
hdl/checkTypesPkg.sv
hdl/shiftFifo.sv
hdl/ringFifo.sv
hdl/fifoComparator.sv
hdl/fifoEquivTop.sv
verif/fifoEquivTb.sv

//--- run.sh
#!/bin/sh
# compile and run the FIFO equivalence testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
TOP=fifoEquivTb

verilator --binary --timing --assert \
    -f files.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

"./$BUILD_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0
